//--- hw/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // RV32I major opcodes.
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    localparam int PIPE_DEPTH = 4; // Edges from accepted instruction to retire pulse.

endpackage

//--- hw/decode_fields.sv
`timescale 1ns/1ps

module decode_fields (
    input  logic             CLK,
    input  logic             reset,
    input  logic             inst_valid,
    input  rv_pkg::word_t    inst_pc,
    input  rv_pkg::word_t    inst_word,
    output logic             fields_valid,
    output rv_pkg::word_t    fields_pc,
    output rv_pkg::opcode_t  fields_opcode,
    output rv_pkg::reg_idx_t fields_rd,
    output rv_pkg::reg_idx_t fields_rs1,
    output rv_pkg::reg_idx_t fields_rs2,
    output logic [2:0]       fields_funct3,
    output logic [6:0]       fields_funct7,
    output rv_pkg::word_t    imm_i,
    output rv_pkg::word_t    imm_s,
    output rv_pkg::word_t    imm_b,
    output rv_pkg::word_t    imm_u,
    output rv_pkg::word_t    imm_j
);

    rv_pkg::word_t word_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            fields_valid <= 1'b0;
        end else begin
            fields_valid <= inst_valid;
        end
    end

    always_ff @(posedge CLK) begin
        fields_pc <= inst_pc;
        word_q    <= inst_word;
    end

    assign fields_opcode = word_q[6:0];
    assign fields_rd     = word_q[11:7];
    assign fields_funct3 = word_q[14:12];
    assign fields_rs1    = word_q[19:15];
    assign fields_rs2    = word_q[24:20];
    assign fields_funct7 = word_q[31:25];

    // Every immediate is sign-extended from bit 31 of the word.
    assign imm_i = {{20{word_q[31]}}, word_q[31:20]};
    assign imm_s = {{20{word_q[31]}}, word_q[31:25], word_q[11:7]};
    assign imm_b = {{19{word_q[31]}}, word_q[31], word_q[7], word_q[30:25], word_q[11:8], 1'b0};
    assign imm_u = {word_q[31:12], 12'b0};
    assign imm_j = {{11{word_q[31]}}, word_q[31], word_q[19:12], word_q[20], word_q[30:21],
                    1'b0};

endmodule

//--- hw/decode_format.sv
`timescale 1ns/1ps

module decode_format #(
    parameter int REG_COUNT = 32
) (
    input  logic             CLK,
    input  logic             reset,
    input  logic             fields_valid,
    input  rv_pkg::word_t    fields_pc,
    input  rv_pkg::opcode_t  fields_opcode,
    input  rv_pkg::reg_idx_t fields_rd,
    input  rv_pkg::reg_idx_t fields_rs1,
    input  rv_pkg::reg_idx_t fields_rs2,
    input  logic [2:0]       fields_funct3,
    input  logic [6:0]       fields_funct7,
    input  rv_pkg::word_t    imm_i,
    input  rv_pkg::word_t    imm_s,
    input  rv_pkg::word_t    imm_b,
    input  rv_pkg::word_t    imm_u,
    input  rv_pkg::word_t    imm_j,
    output logic             dec_valid,
    output logic             dec_illegal,
    output rv_pkg::word_t    dec_pc,
    output rv_pkg::opcode_t  dec_opcode,
    output rv_pkg::reg_idx_t dec_rd,
    output rv_pkg::reg_idx_t dec_rs1,
    output rv_pkg::reg_idx_t dec_rs2,
    output logic [2:0]       dec_funct3,
    output logic [6:0]       dec_funct7,
    output rv_pkg::word_t    dec_imm
);

    rv_pkg::word_t imm_i_q, imm_s_q, imm_b_q, imm_u_q, imm_j_q;
    logic          use_rd, use_rs1, use_rs2, bad_opcode, bad_index;

    always_ff @(posedge CLK) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fields_valid;
        end
    end

    always_ff @(posedge CLK) begin
        dec_pc     <= fields_pc;
        dec_opcode <= fields_opcode;
        dec_rd     <= fields_rd;
        dec_rs1    <= fields_rs1;
        dec_rs2    <= fields_rs2;
        dec_funct3 <= fields_funct3;
        dec_funct7 <= fields_funct7;
        imm_i_q    <= imm_i;
        imm_s_q    <= imm_s;
        imm_b_q    <= imm_b;
        imm_u_q    <= imm_u;
        imm_j_q    <= imm_j;
    end

    // The format decides the immediate and which register indices are live.
    always_comb begin
        use_rd     = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        bad_opcode = 1'b0;
        dec_imm    = '0;
        case (dec_opcode)
            rv_pkg::OPC_OP: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_JALR: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                dec_imm = imm_i_q;
            end
            rv_pkg::OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec_imm = imm_b_q;
            end
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                use_rd  = 1'b1;
                dec_imm = imm_u_q;
            end
            rv_pkg::OPC_JAL: begin
                use_rd  = 1'b1;
                dec_imm = imm_j_q;
            end
            rv_pkg::OPC_STORE: begin
                bad_opcode = 1'b1; // Carries its S immediate but never executes.
                dec_imm    = imm_s_q;
            end
            rv_pkg::OPC_LOAD, rv_pkg::OPC_MISC_MEM, rv_pkg::OPC_SYSTEM: begin
                bad_opcode = 1'b1;
                dec_imm    = imm_i_q;
            end
            default: bad_opcode = 1'b1;
        endcase
    end

    assign bad_index = (use_rd && dec_rd >= REG_COUNT) || (use_rs1 && dec_rs1 >= REG_COUNT) ||
                       (use_rs2 && dec_rs2 >= REG_COUNT);

    assign dec_illegal = dec_valid && (bad_opcode || bad_index);

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic             CLK,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_addr,
    input  rv_pkg::word_t    wb_data
);

    rv_pkg::word_t regs [REG_COUNT];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data; // x0 is never written.
        end
    end

    // Indices past the file read zero, and a write in flight is seen at once.
    assign rs1_data = (rs1_addr == '0 || rs1_addr >= REG_COUNT) ? '0 :
                      (wb_en && wb_addr == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0 || rs2_addr >= REG_COUNT) ? '0 :
                      (wb_en && wb_addr == rs2_addr) ? wb_data : regs[rs2_addr];

    a_wb_addr_range: assert property (@(posedge CLK) disable iff (reset)
        wb_en |-> wb_addr < REG_COUNT);

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic             CLK,
    input  logic             reset,
    input  logic             dec_valid,
    input  logic             dec_illegal,
    input  rv_pkg::word_t    dec_pc,
    input  rv_pkg::opcode_t  dec_opcode,
    input  rv_pkg::reg_idx_t dec_rd,
    input  rv_pkg::reg_idx_t dec_rs1,
    input  rv_pkg::reg_idx_t dec_rs2,
    input  logic [2:0]       dec_funct3,
    input  logic [6:0]       dec_funct7,
    input  rv_pkg::word_t    dec_imm,
    output rv_pkg::reg_idx_t rs1_addr,
    output rv_pkg::reg_idx_t rs2_addr,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    output logic             ex_valid,
    output logic             ex_illegal,
    output rv_pkg::word_t    ex_pc,
    output rv_pkg::reg_idx_t ex_rd,
    output logic             ex_we,
    output rv_pkg::word_t    ex_value,
    output logic             ex_taken,
    output rv_pkg::word_t    ex_target
);

    rv_pkg::word_t src1, src2, alu_b, alu_out, value, pc_plus_imm, jalr_sum, target;
    logic [4:0]    shamt;
    logic          is_op, is_branch, is_jal, is_jalr, legal, br_cond, taken, we;

    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    // The previous instruction has not reached writeback yet, so take it from here.
    assign src1 = (ex_we && ex_rd == dec_rs1) ? ex_value : rs1_data;
    assign src2 = (ex_we && ex_rd == dec_rs2) ? ex_value : rs2_data;

    assign is_op     = dec_opcode == rv_pkg::OPC_OP;
    assign is_branch = dec_opcode == rv_pkg::OPC_BRANCH;
    assign is_jal    = dec_opcode == rv_pkg::OPC_JAL;
    assign is_jalr   = dec_opcode == rv_pkg::OPC_JALR;

    assign alu_b = is_op ? src2 : dec_imm;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec_funct3)
            3'b000: alu_out = (is_op && dec_funct7[5]) ? src1 - alu_b : src1 + alu_b;
            3'b001: alu_out = src1 << shamt;
            3'b010: alu_out = {31'b0, $signed(src1) < $signed(alu_b)};
            3'b011: alu_out = {31'b0, src1 < alu_b};
            3'b100: alu_out = src1 ^ alu_b;
            3'b101: alu_out = dec_funct7[5] ? rv_pkg::word_t'($signed(src1) >>> shamt) :
                                              src1 >> shamt;
            3'b110: alu_out = src1 | alu_b;
            default: alu_out = src1 & alu_b;
        endcase
    end

    always_comb begin
        case (dec_funct3)
            3'b000: br_cond = src1 == src2;
            3'b001: br_cond = src1 != src2;
            3'b100: br_cond = $signed(src1) < $signed(src2);
            3'b101: br_cond = $signed(src1) >= $signed(src2);
            3'b110: br_cond = src1 < src2;
            3'b111: br_cond = src1 >= src2;
            default: br_cond = 1'b0; // Reserved encodings never branch.
        endcase
    end

    assign pc_plus_imm = dec_pc + dec_imm;
    assign jalr_sum    = src1 + dec_imm;

    always_comb begin
        case (dec_opcode)
            rv_pkg::OPC_LUI: value = dec_imm;
            rv_pkg::OPC_AUIPC: value = pc_plus_imm;
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: value = dec_pc + 32'd4;
            default: value = alu_out;
        endcase
    end

    assign legal  = dec_valid && !dec_illegal;
    assign taken  = legal && (is_jal || is_jalr || (is_branch && br_cond));
    assign we     = legal && !is_branch && dec_rd != '0;
    assign target = is_jalr ? {jalr_sum[31:1], 1'b0} : pc_plus_imm;

    always_ff @(posedge CLK) begin
        if (reset) begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
            ex_we      <= 1'b0;
            ex_taken   <= 1'b0;
        end else begin
            ex_valid   <= dec_valid;
            ex_illegal <= dec_valid && dec_illegal;
            ex_we      <= we;
            ex_taken   <= taken;
        end
    end

    always_ff @(posedge CLK) begin
        ex_pc     <= dec_pc;
        ex_rd     <= dec_rd;
        ex_value  <= value;
        ex_target <= target;
    end

    a_target_aligned: assert property (@(posedge CLK) disable iff (reset)
        ex_valid && ex_taken |-> ex_target[0] == 1'b0);

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic             CLK,
    input  logic             reset,
    input  logic             ex_valid,
    input  logic             ex_illegal,
    input  rv_pkg::word_t    ex_pc,
    input  rv_pkg::reg_idx_t ex_rd,
    input  logic             ex_we,
    input  rv_pkg::word_t    ex_value,
    input  logic             ex_taken,
    input  rv_pkg::word_t    ex_target,
    output logic             retire_valid,
    output logic             retire_illegal,
    output rv_pkg::word_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output logic             retire_we,
    output rv_pkg::word_t    retire_value,
    output logic             redirect,
    output rv_pkg::word_t    redirect_target,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_addr,
    output rv_pkg::word_t    wb_data
);

    always_ff @(posedge CLK) begin
        if (reset) begin
            retire_valid   <= 1'b0;
            retire_illegal <= 1'b0;
            retire_we      <= 1'b0;
            redirect       <= 1'b0;
        end else begin
            retire_valid   <= ex_valid;
            retire_illegal <= ex_valid && ex_illegal;
            retire_we      <= ex_valid && ex_we;
            redirect       <= ex_valid && ex_taken;
        end
    end

    always_ff @(posedge CLK) begin
        retire_pc       <= ex_pc;
        retire_rd       <= ex_rd;
        retire_value    <= ex_value;
        redirect_target <= ex_target;
    end

    // Writeback happens while the retire record is on display.
    assign wb_en   = retire_we;
    assign wb_addr = retire_rd;
    assign wb_data = retire_value;

    a_no_x0_write: assert property (@(posedge CLK) disable iff (reset)
        retire_we |-> retire_rd != '0);

endmodule

//--- hw/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top #(
    parameter int REG_COUNT = 32
) (
    input  logic             CLK,
    input  logic             reset,
    input  logic             inst_valid,
    input  rv_pkg::word_t    inst_pc,
    input  rv_pkg::word_t    inst_word,
    output logic             retire_valid,
    output logic             retire_illegal,
    output rv_pkg::word_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output logic             retire_we,
    output rv_pkg::word_t    retire_value,
    output logic             redirect,
    output rv_pkg::word_t    redirect_target
);

    logic             fields_valid;
    rv_pkg::word_t    fields_pc;
    rv_pkg::opcode_t  fields_opcode;
    rv_pkg::reg_idx_t fields_rd, fields_rs1, fields_rs2;
    logic [2:0]       fields_funct3;
    logic [6:0]       fields_funct7;
    rv_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;

    logic             dec_valid, dec_illegal;
    rv_pkg::word_t    dec_pc, dec_imm;
    rv_pkg::opcode_t  dec_opcode;
    rv_pkg::reg_idx_t dec_rd, dec_rs1, dec_rs2;
    logic [2:0]       dec_funct3;
    logic [6:0]       dec_funct7;

    rv_pkg::reg_idx_t rs1_addr, rs2_addr, ex_rd, wb_addr;
    rv_pkg::word_t    rs1_data, rs2_data, ex_pc, ex_value, ex_target, wb_data;
    logic             ex_valid, ex_illegal, ex_we, ex_taken, wb_en;

    decode_fields u_decode_fields (
        .CLK, .reset, .inst_valid, .inst_pc, .inst_word,
        .fields_valid, .fields_pc, .fields_opcode, .fields_rd, .fields_rs1, .fields_rs2,
        .fields_funct3, .fields_funct7, .imm_i, .imm_s, .imm_b, .imm_u, .imm_j
    );

    decode_format #(.REG_COUNT(REG_COUNT)) u_decode_format (
        .CLK, .reset,
        .fields_valid, .fields_pc, .fields_opcode, .fields_rd, .fields_rs1, .fields_rs2,
        .fields_funct3, .fields_funct7, .imm_i, .imm_s, .imm_b, .imm_u, .imm_j,
        .dec_valid, .dec_illegal, .dec_pc, .dec_opcode, .dec_rd, .dec_rs1, .dec_rs2,
        .dec_funct3, .dec_funct7, .dec_imm
    );

    reg_file #(.REG_COUNT(REG_COUNT)) u_reg_file (
        .CLK, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wb_en, .wb_addr, .wb_data
    );

    execute_unit u_execute_unit (
        .CLK, .reset,
        .dec_valid, .dec_illegal, .dec_pc, .dec_opcode, .dec_rd, .dec_rs1, .dec_rs2,
        .dec_funct3, .dec_funct7, .dec_imm,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_valid, .ex_illegal, .ex_pc, .ex_rd, .ex_we, .ex_value, .ex_taken, .ex_target
    );

    result_stage u_result_stage (
        .CLK, .reset,
        .ex_valid, .ex_illegal, .ex_pc, .ex_rd, .ex_we, .ex_value, .ex_taken, .ex_target,
        .retire_valid, .retire_illegal, .retire_pc, .retire_rd, .retire_we, .retire_value,
        .redirect, .redirect_target, .wb_en, .wb_addr, .wb_data
    );

endmodule

//--- tb/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

typedef struct {
    int            kind;     // 1 ALU, 2 upper or link, 3 branch, 4 illegal.
    logic          illegal;
    rv_pkg::word_t pc;
    rv_pkg::reg_idx_t rd;
    logic          we;
    rv_pkg::word_t value;
    logic          redirect;
    rv_pkg::word_t target;
    int            edge_no;  // Clock edge that accepts the instruction.
} exp_rec_t;

rv_pkg::word_t model_regs [32];
exp_rec_t      exp_q [$];

// Runs one instruction on the architectural state, in issue order.
function automatic void model_issue(rv_pkg::word_t pc, rv_pkg::word_t w, int edge_no);
    exp_rec_t          r;
    rv_pkg::opcode_t   opc;
    logic [2:0]        f3;
    rv_pkg::word_t     a, b, b2, imm_i, imm_b, imm_u, imm_j;
    logic signed [31:0] sa;
    logic [4:0]        sh;
    opc   = w[6:0];
    f3    = w[14:12];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    r = '{kind: 1, illegal: 1'b0, pc: pc, rd: w[11:7], we: 1'b0, value: '0,
          redirect: 1'b0, target: '0, edge_no: edge_no};
    case (opc)
        rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
            b2 = (opc == rv_pkg::OPC_OP) ? b : imm_i;
            sh = b2[4:0];
            sa = a;
            case (f3)
                3'd0: r.value = (opc == rv_pkg::OPC_OP && w[30]) ? a - b2 : a + b2;
                3'd1: r.value = a << sh;
                3'd2: r.value = ($signed(a) < $signed(b2)) ? 32'd1 : 32'd0;
                3'd3: r.value = (a < b2) ? 32'd1 : 32'd0;
                3'd4: r.value = a ^ b2;
                3'd5: begin
                    if (w[30]) begin
                        r.value = sa >>> sh;
                    end else begin
                        r.value = a >> sh;
                    end
                end
                3'd6: r.value = a | b2;
                default: r.value = a & b2;
            endcase
        end
        rv_pkg::OPC_LUI: begin
            r.kind  = 2;
            r.value = imm_u;
        end
        rv_pkg::OPC_AUIPC: begin
            r.kind  = 2;
            r.value = pc + imm_u;
        end
        rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: begin
            r.kind     = 2;
            r.value    = pc + 32'd4;
            r.redirect = 1'b1;
            r.target   = (opc == rv_pkg::OPC_JAL) ? pc + imm_j : ((a + imm_i) & ~32'd1);
        end
        rv_pkg::OPC_BRANCH: begin
            r.kind   = 3;
            r.target = pc + imm_b;
            case (f3)
                3'd0: r.redirect = a == b;
                3'd1: r.redirect = a != b;
                3'd4: r.redirect = $signed(a) < $signed(b);
                3'd5: r.redirect = $signed(a) >= $signed(b);
                3'd6: r.redirect = a < b;
                3'd7: r.redirect = a >= b;
                default: r.redirect = 1'b0;
            endcase
        end
        default: begin
            r.kind    = 4;
            r.illegal = 1'b1;
        end
    endcase
    r.we = r.kind != 3 && r.kind != 4 && r.rd != 5'd0;
    if (r.we) begin
        model_regs[r.rd] = r.value;
    end
    exp_q.push_back(r);
endfunction

`endif

//--- tb/rv_pipe_tb.sv
`timescale 1ns/1ps

module rv_pipe_tb;

    logic             CLK;
    logic             reset;
    logic             inst_valid;
    rv_pkg::word_t    inst_pc, inst_word;
    logic             retire_valid, retire_illegal, retire_we, redirect;
    rv_pkg::word_t    retire_pc, retire_value, redirect_target;
    rv_pkg::reg_idx_t retire_rd;

    int    cycle_count;
    int    cur_kind;
    int    checks [6];
    int    errs [6];
    string kind_name [6] = '{"reset state", "arithmetic and logic", "upper immediate and link",
                             "branches", "illegal instructions", "latency and forwarding"};

    `include "rv_ref_model.svh"

    rv_pipe_top #(.REG_COUNT(32)) dut0 (
        .CLK, .reset, .inst_valid, .inst_pc, .inst_word,
        .retire_valid, .retire_illegal, .retire_pc, .retire_rd, .retire_we, .retire_value,
        .redirect, .redirect_target
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic word_check(string name, rv_pkg::word_t got, rv_pkg::word_t exp);
        checks[cur_kind]++;
        if (got !== exp) begin
            errs[cur_kind]++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic index_check(string name, rv_pkg::reg_idx_t got, rv_pkg::reg_idx_t exp);
        checks[cur_kind]++;
        if (got !== exp) begin
            errs[cur_kind]++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic flag_check(string name, logic got, logic exp);
        checks[cur_kind]++;
        if (got !== exp) begin
            errs[cur_kind]++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Called at the falling edge, where all retire outputs are settled.
    task automatic check_retire();
        exp_rec_t r;
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                cur_kind = 5;
                errs[5]++;
                $display("A retire appeared at %0t with no instruction outstanding.", $time);
            end else begin
                r = exp_q.pop_front();
                cur_kind = r.kind;
                word_check("retire_pc", retire_pc, r.pc);
                index_check("retire_rd", retire_rd, r.rd);
                flag_check("retire_illegal", retire_illegal, r.illegal);
                flag_check("retire_we", retire_we, r.we);
                flag_check("redirect", redirect, r.redirect);
                if (r.we) begin
                    word_check("retire_value", retire_value, r.value);
                end
                if (r.redirect) begin
                    word_check("redirect_target", redirect_target, r.target);
                end
                cur_kind = 5;
                word_check("retire latency", cycle_count - r.edge_no, rv_pkg::PIPE_DEPTH - 1);
            end
        end else if (exp_q.size() > 0 &&
                     cycle_count - exp_q[0].edge_no > rv_pkg::PIPE_DEPTH - 1) begin
            errs[5]++;
            $display("The instruction at pc %h never retired (time %0t).", exp_q[0].pc, $time);
            void'(exp_q.pop_front());
        end
    endtask

    task automatic drive_cycle(logic valid, rv_pkg::word_t pc, rv_pkg::word_t word);
        @(negedge CLK);
        check_retire();
        inst_valid = valid;
        inst_pc    = pc;
        inst_word  = word;
        if (valid) begin
            model_issue(pc, word, cycle_count + 1);
        end
    endtask

    function automatic rv_pkg::word_t random_inst(rv_pkg::reg_idx_t prev_rd);
        rv_pkg::reg_idx_t rd, rs1, rs2;
        logic [2:0]       f3;
        logic [11:0]      imm;
        int               pick;
        rd  = $urandom_range(0, 31);
        rs1 = $urandom_range(0, 31);
        rs2 = $urandom_range(0, 31);
        f3  = $urandom_range(0, 7);
        imm = $urandom;
        if ($urandom_range(0, 2) == 0) begin
            rs1 = prev_rd; // Back-to-back dependency.
        end else if ($urandom_range(0, 2) == 0) begin
            rs2 = prev_rd;
        end
        pick = $urandom_range(0, 99);
        if (pick < 25) begin
            return {($urandom_range(0, 1) && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00,
                    rs2, rs1, f3, rd, rv_pkg::OPC_OP};
        end else if (pick < 50) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = (f3 == 3'd5 && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
            end
            return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
        end else if (pick < 58) begin
            return {20'($urandom), rd, $urandom_range(0, 1) ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC};
        end else if (pick < 66) begin
            return {20'($urandom), rd, rv_pkg::OPC_JAL};
        end else if (pick < 74) begin
            return {imm, rs1, 3'b000, rd, rv_pkg::OPC_JALR};
        end else if (pick < 90) begin
            f3 = (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3;
            return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_BRANCH};
        end
        case ($urandom_range(0, 4))
            0: return {imm, rs1, f3, rd, rv_pkg::OPC_LOAD};
            1: return {imm, rs1, f3, rd, rv_pkg::OPC_STORE};
            2: return {imm, rs1, f3, rd, rv_pkg::OPC_MISC_MEM};
            3: return {imm, rs1, f3, rd, rv_pkg::OPC_SYSTEM};
            default: return {imm, rs1, f3, rd, 7'b1111111};
        endcase
    endfunction

    initial begin
        rv_pkg::word_t pc;
        rv_pkg::word_t word;
        int            total_checks;
        int            total_errs;
        int            guard;
        void'($urandom(11344));
        CLK         = 1'b0;
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst_pc     = '0;
        inst_word   = '0;
        cycle_count = 0;
        pc          = 32'h0000_1000;
        word        = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        cur_kind = 0;
        repeat (10) begin
            @(negedge CLK);
            flag_check("retire_valid", retire_valid, 1'b0);
            flag_check("redirect", redirect, 1'b0);
        end
        reset = 1'b0;
        repeat (3) begin
            drive_cycle(1'b0, '0, '0);
            cur_kind = 0;
            flag_check("retire_valid", retire_valid, 1'b0);
            flag_check("redirect", redirect, 1'b0);
        end
        $display("test %s: %0d checks, %0d errors", kind_name[0], checks[0], errs[0]);
        for (int n = 0; n < 2000; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) drive_cycle(1'b0, '0, '0);
            end
            word = random_inst(word[11:7]);
            drive_cycle(1'b1, pc, word);
            pc = pc + 32'd4;
        end
        guard = 0;
        while (exp_q.size() > 0 && guard < 20) begin
            drive_cycle(1'b0, '0, '0);
            guard++;
        end
        if (exp_q.size() > 0) begin
            errs[5]++;
            $display("The pipeline did not drain, %0d instructions still outstanding.",
                     exp_q.size());
        end
        total_checks = 0;
        total_errs   = 0;
        for (int k = 1; k < 6; k++) begin
            $display("test %s: %0d checks, %0d errors", kind_name[k], checks[k], errs[k]);
        end
        for (int k = 0; k < 6; k++) begin
            total_checks += checks[k];
            total_errs   += errs[k];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- rv_pipe.f
hw/rv_pkg.sv
hw/decode_fields.sv
hw/decode_format.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/result_stage.sv
hw/rv_pipe_top.sv
+incdir+tb
tb/rv_pipe_tb.sv
